// ==== source/cpuPkg.sv ====
package cpuPkg;

    localparam int dataWidth = 8;      // Word size
    localparam int addrWidth = 7;      // Program store address bits
    localparam int storeDepth = 128;   // Program store bytes
    localparam int flagWidth = 5;      // Flags held in the flag register

    // Bit index of each flag
    localparam int flagSign = 4;
    localparam int flagCarry = 3;
    localparam int flagZero = 2;
    localparam int flagParity = 1;
    localparam int flagOverflow = 0;

    typedef enum logic [7:0] {
        opHalt = 8'h00,
        opInc  = 8'h01,        // One operand, B forced to one
        opDec  = 8'h02,
        opNot  = 8'h03,        // One operand
        opJump = 8'h04,        // Signed offset byte
        opAdd  = 8'h10,
        opSub  = 8'h20,
        opMul  = 8'h30,
        opDiv  = 8'h40,
        opMod  = 8'h50,
        opAnd  = 8'h60,
        opOr   = 8'h70,
        opXor  = 8'h80,
        opNand = 8'h90,
        opNor  = 8'hA0,
        opXnor = 8'hB0,
        opCmp  = 8'hC0
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluMul, aluDiv, aluMod, aluCmp, aluAnd,
        aluOr, aluXor, aluNand, aluNor, aluXnor, aluNot
    } aluOpT;

    typedef enum logic [3:0] {
        stIdle, stFetchAddr, stFetchRead, stDecode, stOperandAAddr,
        stOperandARead, stOperandBAddr, stOperandBRead, stExecute, stJump,
        stEmitRequest, stEmitRelease, stHalted
    } cpuStateT;

    typedef enum logic [1:0] {selOpcode, selResult, selFlags} answerSelT;   // Answer byte order

    typedef enum logic [1:0] {selMemory, selOne} operandSelT;   // Operand bus source

endpackage

// ==== source/cpuControlIf.sv ====
interface cpuControlIf import cpuPkg::*; ();

    logic loadIr;              // Latch opcode
    logic loadA;               // Latch operand A
    logic loadB;               // Latch operand B or offset
    logic loadResult;          // Capture ALU result and flags
    logic clearPc;             // Restart at address 0
    logic incPc;               // Step past a consumed byte
    logic jumpPc;              // PC plus signed offset
    operandSelT operandSel;    // Memory byte or constant one
    answerSelT answerSel;      // Byte shown on the answer port

    modport controller (output loadIr, loadA, loadB, loadResult, clearPc, incPc, jumpPc,
        operandSel, answerSel);

    modport datapath (input loadIr, loadA, loadB, loadResult, clearPc, incPc, jumpPc,
        operandSel, answerSel);

endinterface

// ==== source/programStore.sv ====
module programStore import cpuPkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 loadReq,
    input  logic [addrWidth-1:0] loadAddress,
    input  logic [dataWidth-1:0] loadData,
    output logic                 loadAck,
    input  logic                 running,
    input  logic [addrWidth-1:0] readAddress,
    output logic [dataWidth-1:0] readData
);

    logic [dataWidth-1:0] memory [storeDepth];
    logic writeEnable;

    // New request only, and never while a program runs
    assign writeEnable = loadReq && !loadAck && !running;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            loadAck <= 1'b0;
        end else if (writeEnable) begin
            loadAck <= 1'b1;                       // Byte written this edge
        end else if (loadAck && !loadReq) begin
            loadAck <= 1'b0;                       // Host released, close the cycle
        end
    end

    always_ff @(posedge clock) begin
        if (writeEnable) begin
            memory[loadAddress] <= loadData;
        end
        readData <= memory[readAddress];           // One cycle read latency
    end

endmodule

// ==== source/alu.sv ====
module alu import cpuPkg::*; (
    input  logic [dataWidth-1:0] operandA,
    input  logic [dataWidth-1:0] operandB,
    input  aluOpT                aluOp,
    output logic [dataWidth-1:0] result,
    output logic [flagWidth-1:0] flags
);

    logic [dataWidth:0]     sum;         // Carry in the top bit
    logic [dataWidth-1:0]   difference;
    logic [2*dataWidth-1:0] product;     // Full width for overflow check
    logic                   divByZero;
    logic                   carry;
    logic                   overflow;

    assign sum = {1'b0, operandA} + {1'b0, operandB};
    assign difference = operandA - operandB;
    assign product = operandA * operandB;
    assign divByZero = (operandB == '0);

    always_comb begin
        result = '0;
        carry = 1'b0;
        overflow = 1'b0;
        case (aluOp)
            aluAdd: begin
                result = sum[dataWidth-1:0];
                carry = sum[dataWidth];
                overflow = (operandA[dataWidth-1] == operandB[dataWidth-1]) &&
                    (result[dataWidth-1] != operandA[dataWidth-1]);    // Signed overflow
            end
            aluSub: begin
                result = difference;
                carry = operandA < operandB;                            // Borrow
                overflow = (operandA[dataWidth-1] != operandB[dataWidth-1]) &&
                    (result[dataWidth-1] != operandA[dataWidth-1]);
            end
            aluMul: begin
                result = product[dataWidth-1:0];                        // Low byte only
                overflow = (product[2*dataWidth-1:dataWidth] != '0);
            end
            aluDiv: result = divByZero ? '1 : operandA / operandB;
            aluMod: result = divByZero ? '1 : operandA % operandB;
            aluCmp: begin
                if (operandA > operandB) begin
                    result = dataWidth'(1);
                end else if (operandA < operandB) begin
                    result = dataWidth'(2);
                end
            end
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluXor:  result = operandA ^ operandB;
            aluNand: result = ~(operandA & operandB);
            aluNor:  result = ~(operandA | operandB);
            aluXnor: result = ~(operandA ^ operandB);
            aluNot:  result = ~operandA;                                // B ignored
            default: result = '0;
        endcase

        flags = '0;
        flags[flagSign] = result[dataWidth-1];
        flags[flagCarry] = carry;
        flags[flagZero] = (result == '0);
        flags[flagParity] = ^result;
        flags[flagOverflow] = overflow;
        if (aluOp == aluCmp) begin
            flags = '0;                                                 // Code only, no flags
        end else if ((aluOp == aluDiv || aluOp == aluMod) && divByZero) begin
            flags = '1;                                                 // Error marker
        end
    end

endmodule

// ==== source/dataPath.sv ====
module dataPath import cpuPkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    cpuControlIf.datapath        ctrl,
    input  logic [dataWidth-1:0] readData,
    output logic [addrWidth-1:0] readAddress,
    input  logic [dataWidth-1:0] aluResult,
    input  logic [flagWidth-1:0] aluFlags,
    output logic [dataWidth-1:0] operandA,
    output logic [dataWidth-1:0] operandB,
    output opcodeT               ir,
    output logic [dataWidth-1:0] answerData
);

    logic [addrWidth-1:0] pc;
    logic [dataWidth-1:0] operandBus;
    logic [dataWidth-1:0] resultReg;
    logic [flagWidth-1:0] flagReg;

    assign operandBus = (ctrl.operandSel == selOne) ? dataWidth'(1) : readData;
    assign readAddress = pc;                                   // Store always reads at PC

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc <= '0;
            ir <= opHalt;
        end else begin
            if (ctrl.clearPc) begin
                pc <= '0;
            end else if (ctrl.jumpPc) begin
                pc <= pc + operandB[addrWidth-1:0];            // Wraps modulo 128
            end else if (ctrl.incPc) begin
                pc <= pc + 1'b1;
            end
            if (ctrl.loadIr) begin
                ir <= opcodeT'(operandBus);                    // Unknown codes kept as is
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.loadA) begin
            operandA <= operandBus;
        end
        if (ctrl.loadB) begin
            operandB <= operandBus;
        end
        if (ctrl.loadResult) begin
            resultReg <= aluResult;
            flagReg <= aluFlags;
        end else if (ctrl.jumpPc) begin
            resultReg <= operandB;                             // Jump reports its offset
            flagReg <= '0;
        end
    end

    always_comb begin
        case (ctrl.answerSel)
            selOpcode: answerData = ir;
            selResult: answerData = resultReg;
            selFlags:  answerData = {{(dataWidth-flagWidth){1'b0}}, flagReg};
            default:   answerData = '0;
        endcase
    end

endmodule

// ==== source/controlUnit.sv ====
module controlUnit import cpuPkg::*; (
    input  logic            clock,
    input  logic            reset,
    cpuControlIf.controller ctrl,
    input  opcodeT          ir,
    input  logic            start,
    input  logic            answerAck,
    output logic            answerReq,
    output logic            done,
    output logic            running,
    output aluOpT           aluOp
);

    cpuStateT  state;
    cpuStateT  nextState;
    answerSelT byteSel;        // Which record byte is on the port
    logic      oneOperand;
    logic      startNow;

    assign oneOperand = (ir == opInc) || (ir == opDec) || (ir == opNot);
    assign startNow = start && (state == stIdle || state == stHalted);
    assign answerReq = (state == stEmitRequest);
    assign done = (state == stHalted);
    assign running = (state != stIdle) && (state != stHalted);   // Blocks host loads

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= stIdle;
            byteSel <= selOpcode;
        end else begin
            state <= nextState;
            if (state == stEmitRelease && !answerAck) begin
                case (byteSel)
                    selOpcode: byteSel <= selResult;
                    selResult: byteSel <= selFlags;
                    default:   byteSel <= selOpcode;              // Record complete
                endcase
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stIdle, stHalted: if (startNow) nextState = stFetchAddr;
            stFetchAddr:      nextState = stFetchRead;
            stFetchRead:      nextState = stDecode;
            stDecode: begin
                case (ir)
                    opJump: nextState = stOperandBAddr;           // Offset goes to B
                    opInc, opDec, opNot, opAdd, opSub, opMul, opDiv, opMod,
                    opAnd, opOr, opXor, opNand, opNor, opXnor, opCmp:
                        nextState = stOperandAAddr;
                    default: nextState = stHalted;                 // Halt and unknown codes
                endcase
            end
            stOperandAAddr:   nextState = stOperandARead;
            stOperandARead:   nextState = oneOperand ? stExecute : stOperandBAddr;
            stOperandBAddr:   nextState = stOperandBRead;
            stOperandBRead:   nextState = (ir == opJump) ? stJump : stExecute;
            stExecute, stJump: nextState = stEmitRequest;
            stEmitRequest:    if (answerAck) nextState = stEmitRelease;
            stEmitRelease: begin
                if (!answerAck) begin
                    nextState = (byteSel == selFlags) ? stFetchAddr : stEmitRequest;
                end
            end
            default:          nextState = stIdle;
        endcase
    end

    always_comb begin
        ctrl.loadIr = 1'b0;
        ctrl.loadA = 1'b0;
        ctrl.loadB = 1'b0;
        ctrl.loadResult = 1'b0;
        ctrl.clearPc = startNow;                          // Every run begins at 0
        ctrl.incPc = 1'b0;
        ctrl.jumpPc = 1'b0;
        ctrl.operandSel = selMemory;
        ctrl.answerSel = byteSel;
        case (state)
            stFetchRead: begin
                ctrl.loadIr = 1'b1;
                ctrl.incPc = 1'b1;
            end
            stDecode: begin
                ctrl.loadB = 1'b1;                        // Preset one for inc and dec
                ctrl.operandSel = selOne;
            end
            stOperandARead: begin
                ctrl.loadA = 1'b1;
                ctrl.incPc = 1'b1;
            end
            stOperandBRead: begin
                ctrl.loadB = 1'b1;                        // Overwrites the preset
                ctrl.incPc = 1'b1;
            end
            stExecute: ctrl.loadResult = 1'b1;
            stJump:    ctrl.jumpPc = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        case (ir)
            opInc, opAdd: aluOp = aluAdd;
            opDec, opSub: aluOp = aluSub;
            opNot:  aluOp = aluNot;
            opMul:  aluOp = aluMul;
            opDiv:  aluOp = aluDiv;
            opMod:  aluOp = aluMod;
            opAnd:  aluOp = aluAnd;
            opOr:   aluOp = aluOr;
            opXor:  aluOp = aluXor;
            opNand: aluOp = aluNand;
            opNor:  aluOp = aluNor;
            opXnor: aluOp = aluXnor;
            opCmp:  aluOp = aluCmp;
            default: aluOp = aluAdd;                      // Result unused
        endcase
    end

endmodule

// ==== source/cpuTop.sv ====
module cpuTop import cpuPkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 loadReq,
    input  logic [addrWidth-1:0] loadAddress,
    input  logic [dataWidth-1:0] loadData,
    output logic                 loadAck,
    output logic                 answerReq,
    input  logic                 answerAck,
    output logic [dataWidth-1:0] answerData,
    output logic                 done
);

    logic [addrWidth-1:0] readAddress;
    logic [dataWidth-1:0] readData;
    logic [dataWidth-1:0] operandA;
    logic [dataWidth-1:0] operandB;
    logic [dataWidth-1:0] aluResult;
    logic [flagWidth-1:0] aluFlags;
    opcodeT               ir;
    aluOpT                aluOp;
    logic                 running;

    cpuControlIf ctrlBus ();   // Control unit to datapath strobes

    programStore i_programStore (.clock(clock), .reset(reset), .loadReq(loadReq),
        .loadAddress(loadAddress), .loadData(loadData), .loadAck(loadAck), .running(running),
        .readAddress(readAddress), .readData(readData));

    dataPath i_dataPath (.clock(clock), .reset(reset), .ctrl(ctrlBus.datapath),
        .readData(readData), .readAddress(readAddress), .aluResult(aluResult),
        .aluFlags(aluFlags), .operandA(operandA), .operandB(operandB), .ir(ir),
        .answerData(answerData));

    alu i_alu (.operandA(operandA), .operandB(operandB), .aluOp(aluOp), .result(aluResult),
        .flags(aluFlags));

    controlUnit i_controlUnit (.clock(clock), .reset(reset), .ctrl(ctrlBus.controller),
        .ir(ir), .start(start), .answerAck(answerAck), .answerReq(answerReq), .done(done),
        .running(running), .aluOp(aluOp));

endmodule

// ==== tests/cpuTop_properties.sv ====
module cpuTopProperties import cpuPkg::*; (
    input logic                 clock,
    input logic                 reset,
    input logic                 start,
    input logic                 loadReq,
    input logic                 loadAck,
    input logic                 answerReq,
    input logic                 answerAck,
    input logic [dataWidth-1:0] answerData,
    input logic                 done
);

    timeunit 1ns;
    timeprecision 100ps;

    reqHeld: assert property (@(posedge clock) disable iff (!reset)
        answerReq && !answerAck |=> answerReq)
        else $error("answerReq fell before answerAck");

    dataStable: assert property (@(posedge clock) disable iff (!reset)
        answerReq && !answerAck |=> $stable(answerData))      // Byte held for the host
        else $error("answerData changed during a request");

    ackNeedsReq: assert property (@(posedge clock) disable iff (!reset)
        !loadReq && !loadAck |=> !loadAck)
        else $error("loadAck rose without loadReq");

    // Halted machine stays quiet until the next start
    doneQuiet: assert property (@(posedge clock) disable iff (!reset)
        done && !start |=> done && !answerReq)
        else $error("done dropped or answerReq rose without a start");

endmodule

bind cpuTop cpuTopProperties i_properties (.clock(clock), .reset(reset), .start(start),
    .loadReq(loadReq), .loadAck(loadAck), .answerReq(answerReq), .answerAck(answerAck),
    .answerData(answerData), .done(done));

// ==== tests/cpuTb.sv ====
module cpuTb import cpuPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic                 clock;
    logic                 reset;
    logic                 start;
    logic                 loadReq;
    logic [addrWidth-1:0] loadAddress;
    logic [dataWidth-1:0] loadData;
    logic                 loadAck;
    logic                 answerReq;
    logic                 answerAck;
    logic [dataWidth-1:0] answerData;
    logic                 done;

    logic [7:0] patterns [0:511];   // Raw test records from the pattern file
    int errorCount = 0;
    int testErrors = 0;             // Errors in the current test
    int failedTests = 0;
    int cycleCount = 0;
    int cycleLimit = 0;             // Set once the patterns are read

    cpuTop i_dut (.clock(clock), .reset(reset), .start(start), .loadReq(loadReq),
        .loadAddress(loadAddress), .loadData(loadData), .loadAck(loadAck),
        .answerReq(answerReq), .answerAck(answerAck), .answerData(answerData), .done(done));

    initial clock = 1'b0;
    always #2 clock = ~clock;       // 4 ns period

    // Watchdog on the whole run
    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, the DUT never finished the program", cycleCount);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [7:0] patternAt(input int index);
        return patterns[9'(index)];
    endfunction

    // Walk length fields up to the FF end marker
    function automatic int patternLength();
        int index;
        index = 0;
        while (patternAt(index) !== 8'hFF && index < 512) begin
            index = index + int'(patternAt(index)) + 1;   // Program bytes
            index = index + int'(patternAt(index)) + 1;   // Expected answer bytes
        end
        return index + 1;
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
        input string what);
        if (actual !== expected) begin
            errorCount++;
            testErrors++;
            $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // Called and returns on a falling edge
    task automatic writeByte(input int address, input logic [7:0] value);
        loadReq = 1'b1;
        loadAddress = addrWidth'(address);
        loadData = value;
        do @(negedge clock); while (!loadAck);
        loadReq = 1'b0;                                   // Release after ack
        do @(negedge clock); while (loadAck);
    endtask

    task automatic collectAnswers(input int first, input int count);
        int received;
        int delay;
        received = 0;
        while (!done) begin
            @(negedge clock);
            if (answerReq) begin
                if (received < count) begin
                    checkValue(32'(answerData), 32'(patternAt(first + received)),
                        $sformatf("answer byte %0d", received));
                end
                received++;
                delay = $urandom_range(5, 0);             // Host back-pressure
                repeat (delay) @(negedge clock);
                answerAck = 1'b1;
                do @(negedge clock); while (answerReq);
                answerAck = 1'b0;
            end
        end
        checkValue(received, count, "answer byte count");
    endtask

    task automatic runTest(input int index, input int base, output int nextBase);
        int length;
        int answers;
        length = int'(patternAt(base));
        answers = int'(patternAt(base + length + 1));
        testErrors = 0;
        for (int i = 0; i < length; i++) begin
            writeByte(i, patternAt(base + 1 + i));
        end
        start = 1'b1;                                     // One cycle pulse
        @(negedge clock);
        start = 1'b0;
        collectAnswers(base + length + 2, answers);
        if (testErrors != 0) begin
            failedTests++;
        end
        $display("Test %0d: %0d program bytes, %0d answer bytes, %s", index, length, answers,
            (testErrors == 0) ? "ok" : "mismatch");
        nextBase = base + length + answers + 2;
    endtask

    initial begin
        int base;
        int nextBase;
        int testCount;
        void'($urandom(69338));
        reset = 1'b0;
        start = 1'b0;
        loadReq = 1'b0;
        loadAddress = '0;
        loadData = '0;
        answerAck = 1'b0;
        testCount = 0;
        $readmemh("tests/cpuPatterns.mem", patterns);
        cycleLimit = patternLength() * 40;                // Worst case per pattern byte
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        base = 0;
        while (patternAt(base) !== 8'hFF && base < 512) begin
            runTest(testCount, base, nextBase);
            base = nextBase;
            testCount++;
        end
        $display("Tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== tests/cpuPatterns.mem ====
// Per test: program length, program bytes, answer count, expected answer bytes
// Records are opcode, result, flags {sign carry zero parity overflow}; FF ends the file
01 00
00
16
10 7F 01 10 FF 01 20 05 07 20 80 01
30 10 11 40 64 07 50 64 07 00
15
10 80 13 10 00 0C 20 FE 1A 20 7F 03
30 10 03 40 0E 02 50 02 02
19
01 FF 02 00 03 0F 60 F0 3C 70 F0 0C 80 AA 0F
90 FF 01 A0 F0 0F B0 0F 01 00
1B
01 00 0C 02 FF 18 03 F0 10 60 30 00 70 FC 10
80 A5 10 90 FE 12 A0 00 04 B0 F1 12
10
40 12 00 50 12 00 C0 33 33 C0 80 7F C0 01 FE 00
0F
40 FF 1F 50 FF 1F C0 00 00 C0 01 00 C0 02 00
0D
04 03 10 01 01 03 00 04 83 20 00 00 00
09
04 03 00 03 FF 10 04 83 00
04 10 03 04 00
03 10 07 02
FF

// ==== files.f ====
source/cpuPkg.sv
source/cpuControlIf.sv
source/programStore.sv
source/alu.sv
source/dataPath.sv
source/controlUnit.sv
source/cpuTop.sv
tests/cpuTop_properties.sv
tests/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -f files.f \
    --top-module cpuTb --Mdir obj_dir -o cpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Finished with errors" "$logFile"; then
    exit 1
fi
exit 0
